// File: bench/llkipp_key_model.sv
// Behavioral key store for the protocol processor testbench
// Counts key words, reports a complete key and answers clear requests
// Ready drops while the key is complete or when the bench forces a stall
`timescale 1ns/1ps

module llkipp_key_model #(
  parameter int KEY_WORDS = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic key_valid_i,
  input  logic clear_key_i,
  input  logic stall_i,
  output logic key_ready_o,
  output logic key_complete_o,
  output logic clear_key_ack_o
);

  // Key words taken since the last clear
  int word_count;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      word_count      <= 0;
      key_complete_o  <= 1'b0;
      clear_key_ack_o <= 1'b0;
    end else begin
      clear_key_ack_o <= 1'b0;
      if (clear_key_ack_o) begin
        // Key is wiped once the ack has gone out
        word_count     <= 0;
        key_complete_o <= 1'b0;
      end else if (clear_key_i) begin
        clear_key_ack_o <= 1'b1;
      end else if (key_valid_i) begin
        word_count <= word_count + 1;
        if (word_count + 1 == KEY_WORDS) begin
          key_complete_o <= 1'b1;
        end
      end
    end
  end

  // Ready for words only while the key is still open
  assign key_ready_o = !key_complete_o && !stall_i;

endmodule

// File: bench/llkipp_tb.sv
// Testbench for the key-loading protocol processor
// Runs a table of request messages over the register bus and checks
// the response word, the key words seen by the key store and bus errors
`timescale 1ns/1ps

module llkipp_tb;

  localparam int KEY_WORDS      = 2;
  localparam int NUM_ROWS       = 11;
  localparam int MAX_WORDS      = 4;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;
  localparam llkipp_pkg::addr_t BAD_ADDR = 32'h0000_0010;

  logic              clk;
  logic              rst;
  logic              we;
  logic              re;
  llkipp_pkg::addr_t addr;
  llkipp_pkg::data_t wdata;
  llkipp_pkg::data_t rdata;
  logic              bus_error;
  logic              ack;
  llkipp_pkg::data_t key_data;
  logic              key_valid;
  logic              key_ready;
  logic              key_complete;
  logic              clear_key;
  logic              clear_key_ack;
  logic              stall;

  // Message table with one row per request
  string             test_name [NUM_ROWS];
  llkipp_pkg::data_t hdr_tab   [NUM_ROWS];
  int                words_tab [NUM_ROWS];
  logic              stall_tab [NUM_ROWS];
  llkipp_pkg::data_t resp_tab  [NUM_ROWS];

  // Words of the current row and what the key store saw of them
  llkipp_pkg::data_t key_words [MAX_WORDS];
  string             row_name;
  int                valid_count;
  int                clear_seen;
  int                errors;
  int                checks;
  int                cycle_count;
  integer            seed;

  llkipp_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .we_i            (we),
    .re_i            (re),
    .addr_i          (addr),
    .wdata_i         (wdata),
    .rdata_o         (rdata),
    .error_o         (bus_error),
    .ack_o           (ack),
    .key_data_o      (key_data),
    .key_valid_o     (key_valid),
    .key_ready_i     (key_ready),
    .key_complete_i  (key_complete),
    .clear_key_o     (clear_key),
    .clear_key_ack_i (clear_key_ack)
  );

  llkipp_key_model #(.KEY_WORDS(KEY_WORDS)) u_key_model (
    .clk             (clk),
    .rst             (rst),
    .key_valid_i     (key_valid),
    .clear_key_i     (clear_key),
    .stall_i         (stall),
    .key_ready_o     (key_ready),
    .key_complete_o  (key_complete),
    .clear_key_ack_o (clear_key_ack)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Request header with length in 31..16, zero status and id in 7..0
  function automatic llkipp_pkg::data_t make_header(input llkipp_pkg::msg_len_t len,
                                                    input llkipp_pkg::msg_id_t id);
    make_header = {32'h0, len, 8'h00, id};
  endfunction

  // Response word always has length 1
  function automatic llkipp_pkg::data_t make_resp(input llkipp_pkg::msg_id_t id,
                                                  input llkipp_pkg::status_t st);
    make_resp = {32'h0, 16'd1, st, id};
  endfunction

  task automatic add_row(input int idx, input string name, input llkipp_pkg::data_t hdr,
                         input int nwords, input logic stl, input llkipp_pkg::data_t resp);
    test_name[idx] = name;
    hdr_tab[idx]   = hdr;
    words_tab[idx] = nwords;
    stall_tab[idx] = stl;
    resp_tab[idx]  = resp;
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic check_word(input string name, input llkipp_pkg::data_t expected,
                            input llkipp_pkg::data_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  // ------------------------------
  // Bus access tasks start 2 ns after a rising edge
  // ------------------------------
  task automatic bus_write(input llkipp_pkg::addr_t a, input llkipp_pkg::data_t d,
                           output logic err);
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(posedge clk);
    #2;
    we = 1'b0;
    // Write ack arrives one cycle after the strobe
    while (!ack) begin
      @(posedge clk);
      #2;
    end
    err = bus_error;
    @(posedge clk);
    #2;
  endtask

  task automatic bus_read(input llkipp_pkg::addr_t a, output llkipp_pkg::data_t d,
                          output logic err, output logic ok);
    re   = 1'b1;
    addr = a;
    // Read answers combinationally within the cycle
    #1;
    d   = rdata;
    err = bus_error;
    ok  = ack;
    @(posedge clk);
    #2;
    re = 1'b0;
  endtask

  // Poll the status register until a response is waiting
  task automatic wait_response();
    llkipp_pkg::data_t d;
    logic              err;
    logic              ok;
    d = '0;
    while (!d[llkipp_pkg::CTRLSTS_RESP_WAITING]) begin
      bus_read(llkipp_pkg::CTRLSTS_ADDR, d, err, ok);
      check_true(ok && !err, "status read was not acked cleanly");
    end
  endtask

  // Idle status shows no response and the store's ready level
  task automatic check_idle_status(input string name);
    llkipp_pkg::data_t d;
    llkipp_pkg::data_t exp;
    logic              err;
    logic              ok;
    repeat (2) @(posedge clk);
    #2;
    exp = {62'h0, key_ready, 1'b0};
    bus_read(llkipp_pkg::CTRLSTS_ADDR, d, err, ok);
    check_true(ok && !err, "idle status read was not acked cleanly");
    check_word({name, " idle status"}, exp, d);
  endtask

  task automatic run_row(input int i);
    llkipp_pkg::data_t resp;
    logic              err;
    logic              ok;
    int                exp_valid;
    int                exp_clear;
    row_name    = test_name[i];
    valid_count = 0;
    clear_seen  = 0;
    stall       = stall_tab[i];
    for (int w = 0; w < MAX_WORDS; w++) begin
      key_words[w] = {$random(seed), $random(seed)};
    end
    bus_write(llkipp_pkg::SENDRECV_ADDR, hdr_tab[i], err);
    check_true(!err, "header write flagged an error");
    for (int w = 0; w < words_tab[i]; w++) begin
      bus_write(llkipp_pkg::SENDRECV_ADDR, key_words[w], err);
      check_true(!err, "key word write flagged an error");
    end
    wait_response();
    // Store sees up to a full key and nothing while stalled
    exp_valid = stall_tab[i] ? 0 : ((words_tab[i] < KEY_WORDS) ? words_tab[i] : KEY_WORDS);
    exp_clear = ((resp_tab[i][7:0] == llkipp_pkg::MID_CLEAR_KEY_ACK) ||
                 (resp_tab[i][15:8] == llkipp_pkg::ST_BAD_KEY_LEN)) ? 1 : 0;
    check_count({test_name[i], " key_valid pulses"}, exp_valid, valid_count);
    check_count({test_name[i], " clear_key seen"}, exp_clear, clear_seen);
    bus_read(llkipp_pkg::SENDRECV_ADDR, resp, err, ok);
    check_true(ok && !err, "response read was not acked cleanly");
    check_word(test_name[i], resp_tab[i], resp);
    check_count({test_name[i], " length field"}, 1, int'(resp[31:16]));
    stall = 1'b0;
    check_idle_status(test_name[i]);
  endtask

  task automatic fill_table();
    add_row(0, "status_empty", make_header(16'd1, llkipp_pkg::MID_KEY_STATUS_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_KEY_STATUS_RESP, llkipp_pkg::ST_KEY_NOT_PRESENT));
    add_row(1, "load_good", make_header(16'd3, llkipp_pkg::MID_LOAD_KEY_REQ), 2, 1'b0,
            make_resp(llkipp_pkg::MID_LOAD_KEY_ACK, llkipp_pkg::ST_GOOD));
    add_row(2, "status_present", make_header(16'd1, llkipp_pkg::MID_KEY_STATUS_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_KEY_STATUS_RESP, llkipp_pkg::ST_KEY_PRESENT));
    add_row(3, "load_overwrite", make_header(16'd3, llkipp_pkg::MID_LOAD_KEY_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_KEY_OVERWRITE));
    add_row(4, "clear_good", make_header(16'd1, llkipp_pkg::MID_CLEAR_KEY_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_CLEAR_KEY_ACK, llkipp_pkg::ST_GOOD));
    add_row(5, "bad_id", make_header(16'd1, 8'h07), 0, 1'b0,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_BAD_MSG_ID));
    add_row(6, "load_short", make_header(16'd1, llkipp_pkg::MID_LOAD_KEY_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_BAD_MSG_LEN));
    add_row(7, "clear_long", make_header(16'd2, llkipp_pkg::MID_CLEAR_KEY_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_BAD_MSG_LEN));
    add_row(8, "load_too_long", make_header(16'd4, llkipp_pkg::MID_LOAD_KEY_REQ), 3, 1'b0,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_BAD_KEY_LEN));
    add_row(9, "load_stalled", make_header(16'd3, llkipp_pkg::MID_LOAD_KEY_REQ), 1, 1'b1,
            make_resp(llkipp_pkg::MID_ERROR_RESP, llkipp_pkg::ST_LOSS_OF_SYNC));
    add_row(10, "status_cleared", make_header(16'd1, llkipp_pkg::MID_KEY_STATUS_REQ), 0, 1'b0,
            make_resp(llkipp_pkg::MID_KEY_STATUS_RESP, llkipp_pkg::ST_KEY_NOT_PRESENT));
  endtask

  // Key store side is sampled on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (key_valid) begin
        if (valid_count < MAX_WORDS) begin
          check_word({row_name, " key word"}, key_words[valid_count], key_data);
        end
        valid_count++;
      end
      if (clear_key) begin
        clear_seen = 1;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no result after %0d cycles, %0d errors so far", cycle_count, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    llkipp_pkg::data_t d;
    logic              err;
    logic              ok;
    seed        = 67;
    cycle_count = 0;
    errors      = 0;
    checks      = 0;
    valid_count = 0;
    clear_seen  = 0;
    row_name    = "after_reset";
    we          = 1'b0;
    re          = 1'b0;
    addr        = '0;
    wdata       = '0;
    stall       = 1'b0;
    rst         = 1'b1;
    fill_table();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    // Outputs held inactive by reset
    check_word("after_reset key_data", '0, key_data);
    check_true(!key_valid && !clear_key && !ack, "key strobe or ack active after reset");
    check_idle_status("after_reset");
    check_count("after_reset key_valid pulses", 0, valid_count);
    check_count("after_reset clear_key seen", 0, clear_seen);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    // Undefined address on both directions
    bus_read(BAD_ADDR, d, err, ok);
    check_true(ok && err, "read of undefined address gave no error with ack");
    check_word("undefined_read_data", '0, d);
    bus_write(BAD_ADDR, 64'h0123_4567_89ab_cdef, err);
    check_true(err, "write to undefined address gave no error with ack");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
source/llkipp_pkg.sv
source/llkipp_top.sv
source/llkipp_reg_decode.sv
source/llkipp_fsm.sv
source/llkipp_word_counter.sv
bench/llkipp_key_model.sv
bench/llkipp_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module llkipp_tb \
  -f compile.f -o llkipp_sim \
  && ./obj_dir/llkipp_sim | tee sim.log \
  && grep -q "Test completed successfully" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass, see sim.log"; exit 1; }

exit 0

// File: source/llkipp_fsm.sv
// Protocol state machine of the key-loading processor
// Checks each request header, passes key words to the key store,
// asks the store to clear its key, and builds the single response word
// Header fields come in on wdata_i whenever sendrecv_wr_i pulses
`timescale 1ns/1ps

module llkipp_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sendrecv_wr_i,
  input  logic                  sendrecv_rd_i,
  input  llkipp_pkg::data_t     wdata_i,
  input  logic                  key_ready_i,
  input  logic                  key_complete_i,
  input  logic                  clear_key_ack_i,
  input  logic                  len_le_one_i,
  input  logic                  len_is_one_i,
  input  logic                  last_word_i,
  output logic                  len_load_o,
  output logic                  len_dec_o,
  output llkipp_pkg::msg_len_t  hdr_len_o,
  output llkipp_pkg::data_t     key_data_o,
  output logic                  key_valid_o,
  output logic                  clear_key_o,
  output logic                  resp_waiting_o,
  output llkipp_pkg::data_t     resp_word_o
);

  llkipp_pkg::llkipp_state_e state_q;
  llkipp_pkg::msg_id_t       msg_id_q;
  llkipp_pkg::status_t       status_q;
  logic                      key_accept;

  // Counter is loaded from the header as it is captured
  assign len_load_o = (state_q == llkipp_pkg::IDLE) && sendrecv_wr_i;
  assign hdr_len_o  = wdata_i[31:16];

  // A key word goes to the store only when it is ready and not yet full
  assign key_accept = (state_q == llkipp_pkg::LOAD_KEY_WORDS) && sendrecv_wr_i &&
                      !key_complete_i && key_ready_i;
  // The last word ends the load, so only earlier words count down
  assign len_dec_o  = key_accept && !last_word_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q        <= llkipp_pkg::IDLE;
      msg_id_q       <= '0;
      status_q       <= '0;
      key_data_o     <= '0;
      key_valid_o    <= 1'b0;
      clear_key_o    <= 1'b0;
      resp_waiting_o <= 1'b0;
      resp_word_o    <= '0;
    end else begin
      // Key discrete outputs are pulses unless a state holds them
      key_data_o  <= '0;
      key_valid_o <= 1'b0;
      clear_key_o <= 1'b0;

      case (state_q)
        // ------------------------------
        llkipp_pkg::IDLE: begin
          resp_waiting_o <= 1'b0;
          resp_word_o    <= '0;
          if (sendrecv_wr_i) begin
            msg_id_q <= wdata_i[7:0];
            status_q <= wdata_i[15:8];
            state_q  <= llkipp_pkg::MESSAGE_CHECK;
          end
        end

        // ------------------------------
        llkipp_pkg::MESSAGE_CHECK: begin
          // Most outcomes answer right away
          state_q <= llkipp_pkg::RESPONSE;
          case (msg_id_q)
            llkipp_pkg::MID_LOAD_KEY_REQ: begin
              // Load needs at least one key word after the header
              if (len_le_one_i) begin
                msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
                status_q <= llkipp_pkg::ST_BAD_MSG_LEN;
              end else if (key_complete_i) begin
                msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
                status_q <= llkipp_pkg::ST_KEY_OVERWRITE;
              end else begin
                state_q <= llkipp_pkg::LOAD_KEY_WORDS;
              end
            end
            llkipp_pkg::MID_CLEAR_KEY_REQ: begin
              if (!len_is_one_i) begin
                msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
                status_q <= llkipp_pkg::ST_BAD_MSG_LEN;
              end else begin
                state_q <= llkipp_pkg::CLEAR_KEY;
              end
            end
            llkipp_pkg::MID_KEY_STATUS_REQ: begin
              if (!len_is_one_i) begin
                msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
                status_q <= llkipp_pkg::ST_BAD_MSG_LEN;
              end else begin
                msg_id_q <= llkipp_pkg::MID_KEY_STATUS_RESP;
                status_q <= key_complete_i ? llkipp_pkg::ST_KEY_PRESENT
                                           : llkipp_pkg::ST_KEY_NOT_PRESENT;
              end
            end
            default: begin
              msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
              status_q <= llkipp_pkg::ST_BAD_MSG_ID;
            end
          endcase
        end

        // ------------------------------
        llkipp_pkg::LOAD_KEY_WORDS: begin
          if (sendrecv_wr_i) begin
            // Store already full means the key is too long, wipe it first
            if (key_complete_i) begin
              msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
              status_q <= llkipp_pkg::ST_BAD_KEY_LEN;
              state_q  <= llkipp_pkg::CLEAR_KEY;
            end else if (!key_ready_i) begin
              // Word is dropped
              msg_id_q <= llkipp_pkg::MID_ERROR_RESP;
              status_q <= llkipp_pkg::ST_LOSS_OF_SYNC;
              state_q  <= llkipp_pkg::RESPONSE;
            end else begin
              key_data_o  <= wdata_i;
              key_valid_o <= 1'b1;
              if (last_word_i) begin
                msg_id_q <= llkipp_pkg::MID_LOAD_KEY_ACK;
                status_q <= llkipp_pkg::ST_GOOD;
                state_q  <= llkipp_pkg::WAIT_FOR_COMPLETE;
              end
            end
          end
        end

        // Store takes a variable time to finish the key
        llkipp_pkg::WAIT_FOR_COMPLETE: begin
          if (key_complete_i) begin
            state_q <= llkipp_pkg::RESPONSE;
          end
        end

        // ------------------------------
        llkipp_pkg::CLEAR_KEY: begin
          // Hold the request until the store acks it
          clear_key_o <= !clear_key_ack_i;
          if (clear_key_ack_i) begin
            // Bad key length keeps its error response
            if (msg_id_q != llkipp_pkg::MID_ERROR_RESP) begin
              msg_id_q <= llkipp_pkg::MID_CLEAR_KEY_ACK;
              status_q <= llkipp_pkg::ST_GOOD;
            end
            state_q <= llkipp_pkg::RESPONSE;
          end
        end

        // ------------------------------
        llkipp_pkg::RESPONSE: begin
          resp_word_o    <= llkipp_pkg::data_t'({llkipp_pkg::RESP_MSG_LEN, status_q, msg_id_q});
          resp_waiting_o <= 1'b1;
          // Host has taken the response
          if (sendrecv_rd_i) begin
            resp_waiting_o <= 1'b0;
            state_q        <= llkipp_pkg::IDLE;
          end
        end

        default: begin
          state_q <= llkipp_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/llkipp_pkg.sv
// Shared definitions for the key-loading protocol processor
// Bus widths, register addresses, message ids, status codes and FSM states
// Referenced by scoped names from every RTL file of the design

package llkipp_pkg;

  // ------------------------------
  // Widths and vector types
  // ------------------------------
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 64;

  // Register bus address
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Bus data, key word and response word
  typedef logic [DATA_WIDTH-1:0] data_t;
  // Header fields
  typedef logic [7:0]  msg_id_t;
  typedef logic [7:0]  status_t;
  typedef logic [15:0] msg_len_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam addr_t CTRLSTS_ADDR  = 32'h0000_0000;
  localparam addr_t SENDRECV_ADDR = 32'h0000_0008;

  // Control/status register bits
  localparam int CTRLSTS_WIDTH         = 2;
  localparam int CTRLSTS_RESP_WAITING  = 0;
  localparam int CTRLSTS_READY_FOR_KEY = 1;

  // Every response carries only its header
  localparam msg_len_t RESP_MSG_LEN = 16'd1;

  // ------------------------------
  // Message ids
  // ------------------------------
  localparam msg_id_t MID_LOAD_KEY_REQ    = 8'h00;
  localparam msg_id_t MID_CLEAR_KEY_REQ   = 8'h01;
  localparam msg_id_t MID_KEY_STATUS_REQ  = 8'h02;
  localparam msg_id_t MID_LOAD_KEY_ACK    = 8'h03;
  localparam msg_id_t MID_CLEAR_KEY_ACK   = 8'h04;
  localparam msg_id_t MID_KEY_STATUS_RESP = 8'h05;
  localparam msg_id_t MID_ERROR_RESP      = 8'h06;

  // ------------------------------
  // Status codes
  // ------------------------------
  localparam status_t ST_GOOD            = 8'h00;
  localparam status_t ST_KEY_PRESENT     = 8'h01;
  localparam status_t ST_KEY_NOT_PRESENT = 8'h02;
  // Error codes sit in their own range
  localparam status_t ST_BAD_MSG_ID      = 8'h20;
  localparam status_t ST_BAD_MSG_LEN     = 8'h21;
  localparam status_t ST_KEY_OVERWRITE   = 8'h22;
  localparam status_t ST_LOSS_OF_SYNC    = 8'h23;
  localparam status_t ST_BAD_KEY_LEN     = 8'h24;

  // Protocol FSM states
  typedef enum logic [2:0] {
    IDLE              = 3'd0,
    MESSAGE_CHECK     = 3'd1,
    LOAD_KEY_WORDS    = 3'd2,
    WAIT_FOR_COMPLETE = 3'd3,
    CLEAR_KEY         = 3'd4,
    RESPONSE          = 3'd5
  } llkipp_state_e;

endpackage

// File: source/llkipp_reg_decode.sv
// Register decoder for the protocol processor
// Owns all address compares, the control/status register and bus acks
// Reads answer in the same cycle, writes are acked one cycle later
`timescale 1ns/1ps

module llkipp_reg_decode (
  input  logic               clk,
  input  logic               rst,
  llkipp_reg_bus_if.decode   bus,
  input  logic               resp_waiting_i,
  input  llkipp_pkg::data_t  resp_word_i,
  input  logic               key_ready_i,
  output logic               sendrecv_wr_o,
  output logic               sendrecv_rd_o,
  output llkipp_pkg::data_t  rdata_o,
  output logic               error_o,
  output logic               ack_o
);

  logic [llkipp_pkg::CTRLSTS_WIDTH-1:0] ctrlsts_q;
  logic                                 we_q;
  logic                                 write_error_q;
  logic                                 read_error;
  logic                                 hit_ctrlsts;
  logic                                 hit_sendrecv;

  // Address match
  assign hit_ctrlsts  = (bus.addr == llkipp_pkg::CTRLSTS_ADDR);
  assign hit_sendrecv = (bus.addr == llkipp_pkg::SENDRECV_ADDR);

  // One-cycle strobes for the FSM
  assign sendrecv_wr_o = bus.we && hit_sendrecv;
  assign sendrecv_rd_o = bus.re && hit_sendrecv;

  // ------------------------------
  // Status register and write ack
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrlsts_q     <= '0;
      we_q          <= 1'b0;
      write_error_q <= 1'b0;
    end else begin
      // Status bits follow their sources one cycle late
      ctrlsts_q[llkipp_pkg::CTRLSTS_RESP_WAITING]  <= resp_waiting_i;
      ctrlsts_q[llkipp_pkg::CTRLSTS_READY_FOR_KEY] <= key_ready_i;
      we_q          <= bus.we;
      // No writable status bits, so only undefined addresses fail
      write_error_q <= bus.we && !hit_ctrlsts && !hit_sendrecv;
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rdata_o    = '0;
    read_error = 1'b0;
    if (bus.re) begin
      if (hit_ctrlsts) begin
        rdata_o = llkipp_pkg::data_t'(ctrlsts_q);
      end else if (hit_sendrecv) begin
        rdata_o = resp_word_i;
      end else begin
        // Undefined address reads back zero
        read_error = 1'b1;
      end
    end
  end

  // Read ack is immediate, write ack follows the registered strobe
  assign ack_o   = bus.re || we_q;
  assign error_o = read_error || write_error_q;

endmodule

// File: source/llkipp_top.sv
// Top level of the key-loading protocol processor
// Host side is a strobe register bus, key side is the discrete key handshake
// Also holds the internal register bus interface used by the decoder
`timescale 1ns/1ps

// Request half of the register bus, carried from the top to the decoder
interface llkipp_reg_bus_if;
  logic               we;
  logic               re;
  llkipp_pkg::addr_t  addr;
  llkipp_pkg::data_t  wdata;

  // Decoder only observes the request
  modport decode (input we, input re, input addr, input wdata);
endinterface

module llkipp_top (
  input  logic               clk,
  input  logic               rst,
  // Register bus
  input  logic               we_i,
  input  logic               re_i,
  input  llkipp_pkg::addr_t  addr_i,
  input  llkipp_pkg::data_t  wdata_i,
  output llkipp_pkg::data_t  rdata_o,
  output logic               error_o,
  output logic               ack_o,
  // Key discrete
  output llkipp_pkg::data_t  key_data_o,
  output logic               key_valid_o,
  input  logic               key_ready_i,
  input  logic               key_complete_i,
  output logic               clear_key_o,
  input  logic               clear_key_ack_i
);

  // Decoder to FSM
  logic                 sendrecv_wr;
  logic                 sendrecv_rd;
  logic                 resp_waiting;
  llkipp_pkg::data_t    resp_word;

  // FSM to word counter
  logic                 len_load;
  logic                 len_dec;
  llkipp_pkg::msg_len_t hdr_len;
  logic                 len_le_one;
  logic                 len_is_one;
  logic                 last_word;

  // ------------------------------
  // Bus request bundle
  // ------------------------------
  llkipp_reg_bus_if bus ();

  assign bus.we    = we_i;
  assign bus.re    = re_i;
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_i;

  llkipp_reg_decode u_decode (
    .clk            (clk),
    .rst            (rst),
    .bus            (bus.decode),
    .resp_waiting_i (resp_waiting),
    .resp_word_i    (resp_word),
    .key_ready_i    (key_ready_i),
    .sendrecv_wr_o  (sendrecv_wr),
    .sendrecv_rd_o  (sendrecv_rd),
    .rdata_o        (rdata_o),
    .error_o        (error_o),
    .ack_o          (ack_o)
  );

  // Write data goes straight to the FSM, the strobe tells it when to look
  llkipp_fsm u_fsm (
    .clk             (clk),
    .rst             (rst),
    .sendrecv_wr_i   (sendrecv_wr),
    .sendrecv_rd_i   (sendrecv_rd),
    .wdata_i         (bus.wdata),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_ack_i (clear_key_ack_i),
    .len_le_one_i    (len_le_one),
    .len_is_one_i    (len_is_one),
    .last_word_i     (last_word),
    .len_load_o      (len_load),
    .len_dec_o       (len_dec),
    .hdr_len_o       (hdr_len),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .clear_key_o     (clear_key_o),
    .resp_waiting_o  (resp_waiting),
    .resp_word_o     (resp_word)
  );

  llkipp_word_counter u_counter (
    .clk          (clk),
    .rst          (rst),
    .len_load_i   (len_load),
    .len_dec_i    (len_dec),
    .hdr_len_i    (hdr_len),
    .len_le_one_o (len_le_one),
    .len_is_one_o (len_is_one),
    .last_word_o  (last_word)
  );

endmodule

// File: source/llkipp_word_counter.sv
// Message length counter for the protocol processor
// Loaded with the header length, counts down once per key word
// Flags tell the FSM about short headers and the last key word
`timescale 1ns/1ps

module llkipp_word_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  len_load_i,
  input  logic                  len_dec_i,
  input  llkipp_pkg::msg_len_t  hdr_len_i,
  output logic                  len_le_one_o,
  output logic                  len_is_one_o,
  output logic                  last_word_o
);

  // Remaining words, header included
  llkipp_pkg::msg_len_t len_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      len_q <= '0;
    end else if (len_load_i) begin
      len_q <= hdr_len_i;
    end else if (len_dec_i) begin
      len_q <= len_q - 16'd1;
    end
  end

  // Header only, or nothing at all
  assign len_le_one_o = (len_q <= 16'd1);
  assign len_is_one_o = (len_q == 16'd1);
  // Header plus one key word left
  assign last_word_o  = (len_q == 16'd2);

endmodule
